/* all.f */
source/coreIsaPkg.sv
source/corePipePkg.sv
source/rfPortIf.sv
source/instDecode.sv
source/regFile.sv
source/aluExecute.sv
source/coreBackend.sv
tb/clockGen.sv
tb/coreBackend_assert.sv
tb/coreBackendTb.sv

/* source/aluExecute.sv */
// Execute unit: Q102H operand select and ALU, Q103H-Q105H result pipe, writeback outputs
module aluExecute (
    input  logic                           Clock,
    input  logic                           rstN,
    input  corePipePkg::tCtrlExe           ctrlQ102H,
    input  logic [31:0]                    pcQ102H,
    input  logic [31:0]                    immQ102H,
    input  logic [31:0]                    rdData1Q102H,
    input  logic [31:0]                    rdData2Q102H,
    rfPortIf.writeback                     rfPort,
    output logic                           wbValid,
    output logic [coreIsaPkg::regIdxW-1:0] wbRd,
    output logic [coreIsaPkg::xlen-1:0]    wbData
);
    import coreIsaPkg::*;

    logic [xlen-1:0]    opA;
    logic [xlen-1:0]    opB;
    logic [xlen-1:0]    resultQ102H;

    // Per-stage control
    logic               validQ103H, validQ104H, validQ105H;
    logic               wrEnQ103H, wrEnQ104H, wrEnQ105H;
    logic [regIdxW-1:0] dstQ103H, dstQ104H, dstQ105H;
    // Per-stage result
    logic [xlen-1:0]    dataQ103H, dataQ104H, dataQ105H;

    // ------------------------------------------------------------
    // Q102H operands and ALU
    // ------------------------------------------------------------
    assign opA = ctrlQ102H.selPc ? pcQ102H : rdData1Q102H;
    assign opB = ctrlQ102H.selImm ? immQ102H : rdData2Q102H;

    always_comb begin
        unique case (ctrlQ102H.aluOp)
            aluAdd:   resultQ102H = opA + opB;
            aluSub:   resultQ102H = opA - opB;
            aluAnd:   resultQ102H = opA & opB;
            aluOr:    resultQ102H = opA | opB;
            aluXor:   resultQ102H = opA ^ opB;
            aluSlt:   resultQ102H = {31'b0, $signed(opA) < $signed(opB)};
            // Shift amount is the low 5 bits only
            aluSll:   resultQ102H = opA << opB[4:0];
            aluSrl:   resultQ102H = opA >> opB[4:0];
            aluPassB: resultQ102H = opB;
            default:  resultQ102H = '0;
        endcase
    end

    // ------------------------------------------------------------
    // Q103H to Q105H pipe
    // ------------------------------------------------------------
    // Control bits, cleared on reset
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            validQ103H <= 1'b0;
            validQ104H <= 1'b0;
            validQ105H <= 1'b0;
            wrEnQ103H <= 1'b0;
            wrEnQ104H <= 1'b0;
            wrEnQ105H <= 1'b0;
        end else if (rfPort.ready) begin
            validQ103H <= ctrlQ102H.valid;
            validQ104H <= validQ103H;
            validQ105H <= validQ104H;
            wrEnQ103H <= ctrlQ102H.regWrEn;
            wrEnQ104H <= wrEnQ103H;
            wrEnQ105H <= wrEnQ104H;
        end
    end

    // Destination and data
    always_ff @(posedge Clock) begin
        if (rfPort.ready) begin
            dstQ103H <= ctrlQ102H.regDst;
            dstQ104H <= dstQ103H;
            dstQ105H <= dstQ104H;
            dataQ103H <= resultQ102H;
            dataQ104H <= dataQ103H;
            dataQ105H <= dataQ104H;
        end
    end

    // ------------------------------------------------------------
    // Q105H writeback
    // ------------------------------------------------------------
    assign rfPort.regWrEn = validQ105H && wrEnQ105H;
    assign rfPort.regDst = dstQ105H;
    assign rfPort.regWrData = dataQ105H;

    // Reported once, on the edge that commits the write
    assign wbValid = validQ105H && wrEnQ105H && (dstQ105H != '0) && rfPort.ready;
    assign wbRd = dstQ105H;
    assign wbData = dataQ105H;

endmodule

/* source/coreBackend.sv */
// Top level: ready from stall, rfPortIf, decoder, register file and execute unit
module coreBackend #(
    parameter int numRegs = 32
) (
    input  logic                           Clock,
    input  logic                           rstN,
    input  logic                           instValid,
    input  logic                           stall,
    input  logic [31:0]                    instPc,
    input  logic [31:0]                    instWord,
    output logic                           wbValid,
    output logic [coreIsaPkg::regIdxW-1:0] wbRd,
    output logic [coreIsaPkg::xlen-1:0]    wbData
);
    import coreIsaPkg::*;
    import corePipePkg::*;

    tCtrlExe            ctrlQ102H;
    logic [xlen-1:0]    pcQ102H;
    logic [xlen-1:0]    immQ102H;
    logic [xlen-1:0]    rdData1Q102H;
    logic [xlen-1:0]    rdData2Q102H;

    rfPortIf rfIf ();

    // Stall freezes every stage at once
    assign rfIf.ready = ~stall;

    // ------------------------------------------------------------
    // Q101H decode and register read, side by side
    // ------------------------------------------------------------
    instDecode #(
        .numRegs (numRegs)
    ) uDecode (
        .Clock     (Clock),
        .rstN      (rstN),
        .instValid (instValid),
        .ready     (rfIf.ready),
        .instPc    (instPc),
        .instWord  (instWord),
        .rfPort    (rfIf.decode),
        .ctrlQ102H (ctrlQ102H),
        .pcQ102H   (pcQ102H),
        .immQ102H  (immQ102H)
    );

    regFile #(
        .numRegs (numRegs)
    ) uRegFile (
        .Clock        (Clock),
        .rfPort       (rfIf.rf),
        .rdData1Q102H (rdData1Q102H),
        .rdData2Q102H (rdData2Q102H)
    );

    // Q102H to Q105H, writes back through rfIf
    aluExecute uExecute (
        .Clock        (Clock),
        .rstN         (rstN),
        .ctrlQ102H    (ctrlQ102H),
        .pcQ102H      (pcQ102H),
        .immQ102H     (immQ102H),
        .rdData1Q102H (rdData1Q102H),
        .rdData2Q102H (rdData2Q102H),
        .rfPort       (rfIf.writeback),
        .wbValid      (wbValid),
        .wbRd         (wbRd),
        .wbData       (wbData)
    );

endmodule

/* source/coreIsaPkg.sv */
// RV32I ISA package: data and index widths, major opcode enum, ALU operation enum
package coreIsaPkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    // Data path width
    localparam int xlen = 32;
    // Register index field width, same for rs1, rs2 and rd
    localparam int regIdxW = 5;

    // ------------------------------------------------------------
    // Major opcodes, instWord[6:0]
    // ------------------------------------------------------------
    // Only the integer ALU group and the two upper-immediate forms
    typedef enum logic [6:0] {
        opcOp    = 7'b0110011,  // Register-register
        opcOpImm = 7'b0010011,  // Register-immediate
        opcLui   = 7'b0110111,
        opcAuipc = 7'b0010111
    } tOpcode;

    // ------------------------------------------------------------
    // ALU operations
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,     // Signed compare
        aluSll,
        aluSrl,     // Logical, zero fill
        aluPassB    // Second operand straight through, for LUI
    } tAluOp;

endpackage

/* source/corePipePkg.sv */
// Pipeline package: Q102H execute control struct
package corePipePkg;

    // ------------------------------------------------------------
    // Execute control, built in Q101H and registered into Q102H
    // ------------------------------------------------------------
    typedef struct packed {
        // Operation for the Q102H ALU
        coreIsaPkg::tAluOp                 aluOp;
        // Operand B from the immediate instead of rs2
        logic                              selImm;
        // Operand A from the PC instead of rs1
        logic                              selPc;
        // Writeback destination
        logic [coreIsaPkg::regIdxW-1:0]    regDst;
        logic                              regWrEn;
        // Cleared for bubbles and unsupported opcodes
        logic                              valid;
    } tCtrlExe;

endpackage

/* source/instDecode.sv */
// Q101H instruction decoder: opcode and funct decode, I/U immediate, Q102H control registers
module instDecode #(
    parameter int numRegs = 32
) (
    input  logic                   Clock,
    input  logic                   rstN,
    input  logic                   instValid,
    input  logic                   ready,
    input  logic [31:0]            instPc,
    input  logic [31:0]            instWord,
    rfPortIf.decode                rfPort,
    output corePipePkg::tCtrlExe   ctrlQ102H,
    output logic [31:0]            pcQ102H,
    output logic [31:0]            immQ102H
);
    import coreIsaPkg::*;
    import corePipePkg::*;

    // Keeps indices inside the array, numRegs 16 gives RV32E
    localparam logic [regIdxW-1:0] idxMask = regIdxW'(numRegs - 1);

    tOpcode         opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    logic           legal;
    tCtrlExe        ctrlQ101H;
    logic [31:0]    immQ101H;

    // ------------------------------------------------------------
    // Field extraction
    // ------------------------------------------------------------
    assign opcode = tOpcode'(instWord[6:0]);
    assign funct3 = instWord[14:12];
    assign funct7 = instWord[31:25];

    // Sources go straight to the register file read
    assign rfPort.regSrc1 = instWord[19:15] & idxMask;
    assign rfPort.regSrc2 = instWord[24:20] & idxMask;

    // ------------------------------------------------------------
    // Opcode / funct decode
    // ------------------------------------------------------------
    always_comb begin
        legal = 1'b1;
        ctrlQ101H.aluOp = aluAdd;
        ctrlQ101H.selImm = 1'b0;
        ctrlQ101H.selPc = 1'b0;
        // Default I-type, sign extended
        immQ101H = {{20{instWord[31]}}, instWord[31:20]};
        unique case (opcode)
            opcOp: begin
                // Only SUB sets funct7 bit 5
                unique case (funct3)
                    3'b000: ctrlQ101H.aluOp = funct7[5] ? aluSub : aluAdd;
                    3'b111: ctrlQ101H.aluOp = aluAnd;
                    3'b110: ctrlQ101H.aluOp = aluOr;
                    3'b100: ctrlQ101H.aluOp = aluXor;
                    3'b010: ctrlQ101H.aluOp = aluSlt;
                    3'b001: ctrlQ101H.aluOp = aluSll;
                    3'b101: ctrlQ101H.aluOp = aluSrl;
                    default: legal = 1'b0;
                endcase
                if (funct7 != 7'b0000000 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    legal = 1'b0;
                end
            end
            opcOpImm: begin
                ctrlQ101H.selImm = 1'b1;
                unique case (funct3)
                    3'b000: ctrlQ101H.aluOp = aluAdd;
                    3'b111: ctrlQ101H.aluOp = aluAnd;
                    3'b110: ctrlQ101H.aluOp = aluOr;
                    3'b100: ctrlQ101H.aluOp = aluXor;
                    // SLTI, shifts by immediate not supported
                    default: legal = 1'b0;
                endcase
            end
            opcLui, opcAuipc: begin
                // U-type, low 12 bits zero
                immQ101H = {instWord[31:12], 12'b0};
                ctrlQ101H.selImm = 1'b1;
                ctrlQ101H.selPc = (opcode == opcAuipc);
                ctrlQ101H.aluOp = (opcode == opcAuipc) ? aluAdd : aluPassB;
            end
            default: legal = 1'b0;
        endcase
        ctrlQ101H.regDst = instWord[11:7] & idxMask;
        ctrlQ101H.regWrEn = legal;
        // Unsupported opcode retires as a bubble
        ctrlQ101H.valid = instValid && legal;
    end

    // ------------------------------------------------------------
    // Q102H registers
    // ------------------------------------------------------------
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            ctrlQ102H <= '0;
        end else if (ready) begin
            ctrlQ102H <= ctrlQ101H;
        end
    end

    // Payload only, no reset
    always_ff @(posedge Clock) begin
        if (ready) begin
            pcQ102H <= instPc;
            immQ102H <= immQ101H;
        end
    end

endmodule

/* source/regFile.sv */
// Register file: Q105H write, Q101H read with register 0 and Q105H forwarding, Q102H operands
module regFile #(
    parameter int numRegs = 32
) (
    input  logic           Clock,
    rfPortIf.rf            rfPort,
    output logic [31:0]    rdData1Q102H,
    output logic [31:0]    rdData2Q102H
);
    import coreIsaPkg::*;

    // Register 0 is not stored
    logic [xlen-1:0]    regs [1:numRegs-1];
    logic [xlen-1:0]    rdData1Q101H;
    logic [xlen-1:0]    rdData2Q101H;

    // Zero for x0, Q105H bypass on a match, else the array
    function automatic logic [xlen-1:0] readPort(input logic [regIdxW-1:0] src);
        logic fwdHit;
        fwdHit = rfPort.regWrEn && (src == rfPort.regDst);
        if (src == '0) begin
            return '0;
        end else if (fwdHit) begin
            return rfPort.regWrData;
        end
        return regs[src];
    endfunction

    // ------------------------------------------------------------
    // Q105H write
    // ------------------------------------------------------------
    always_ff @(posedge Clock) begin
        if (rfPort.regWrEn && rfPort.ready && rfPort.regDst != '0) begin
            regs[rfPort.regDst] <= rfPort.regWrData;
        end
    end

    // ------------------------------------------------------------
    // Q101H read
    // ------------------------------------------------------------
    assign rdData1Q101H = readPort(rfPort.regSrc1);
    assign rdData2Q101H = readPort(rfPort.regSrc2);

    // Operands into Q102H, held while stalled
    always_ff @(posedge Clock) begin
        if (rfPort.ready) begin
            rdData1Q102H <= rdData1Q101H;
            rdData2Q102H <= rdData2Q101H;
        end
    end

endmodule

/* source/rfPortIf.sv */
// Register file port interface: Q101H read indices, Q105H write, stage enable, modports
interface rfPortIf;
    import coreIsaPkg::*;

    // Q101H read sources
    logic [regIdxW-1:0] regSrc1;
    logic [regIdxW-1:0] regSrc2;

    // Q105H write
    logic [regIdxW-1:0] regDst;
    logic               regWrEn;
    logic [xlen-1:0]    regWrData;

    // Stage enable, low freezes every stage
    logic               ready;

    // Decoder drives the read indices
    modport decode (
        output regSrc1, regSrc2
    );

    // Execute unit drives the write fields from Q105H
    modport writeback (
        input  ready,
        output regDst, regWrEn, regWrData
    );

    // Register file sees everything
    modport rf (
        input regSrc1, regSrc2, regDst, regWrEn, regWrData, ready
    );

endinterface

/* tb/backendCases.hex */
// Columns: flags (bit 4 valid, bit 0 stall), PC, instruction word
// One line per cycle after reset; stalled lines do not issue
10 00000100 00500093 // addi x1, x0, 5
10 00000104 ffd00113 // addi x2, x0, -3
10 00000108 123451b7 // lui x3, 0x12345
10 0000010c 7ff00213 // addi x4, x0, 0x7ff
10 00000110 001082b3 // add x5, x1, x1, x1 forwarded
10 00000114 40208333 // sub x6, x1, x2
10 00000118 00001397 // auipc x7, 0x1
10 0000011c 0041f433 // and x8, x3, x4
10 00000120 0041e4b3 // or x9, x3, x4
10 00000124 00414533 // xor x10, x2, x4
10 00000128 001125b3 // slt x11, x2, x1
10 0000012c 0020a633 // slt x12, x1, x2
10 00000130 004096b3 // sll x13, x1, x4
10 00000134 00115733 // srl x14, x2, x1
11 00000138 55500f93 // stalled, ignored
11 0000013c 55500f93 // stalled, ignored
10 00000140 12310793 // addi x15, x2, 0x123
10 00000144 fff1f813 // andi x16, x3, -1
10 00000148 0f00e893 // ori x17, x1, 0xf0
10 0000014c fff14913 // xori x18, x2, -1
10 00000150 06400093 // addi x1, x0, 100
10 00000154 00100993 // addi x19, x0, 1
01 00000158 00000000 // stall, not a slot
00 0000015c 00000000 // bubble
10 00000160 00008a33 // add x20, x1, x0, three slots on, old x1
10 00000164 00008ab3 // add x21, x1, x0, four slots on, new x1
10 00000168 03700013 // addi x0, x0, 55
10 0000016c 01300b33 // add x22, x0, x19
10 00000170 00112023 // sw, unsupported
10 00000174 40115d33 // sra, unsupported
10 00000178 00000bb3 // add x23, x0, x0, four slots after x0 write
00 0000017c 00900c13 // invalid addi x24
01 00000180 00000000 // stall
11 00000184 00900c13 // stalled, ignored
10 00000188 015a0cb3 // add x25, x20, x21
10 0000018c 40fb0db3 // sub x27, x22, x15
10 00000190 fffffe17 // auipc x28, 0xfffff
10 00000194 80000eb7 // lui x29, 0x80000
10 00000198 01950f33 // add x30, x10, x25

/* tb/clockGen.sv */
// Testbench clock with period 4 and active-low reset held for 8 cycles
module clockGen (
    output logic Clock,
    output logic rstN
);

    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    // Released on a falling edge, clear of the sampling edge
    initial begin
        rstN = 1'b0;
        repeat (8) @(negedge Clock);
        rstN = 1'b1;
    end

endmodule

/* tb/coreBackendTb.sv */
// Testbench top: cases reader, RV32I reference model, retirement compare tasks, timeout
module coreBackendTb;
    import coreIsaPkg::*;

    localparam int maxCases = 64;
    localparam int pipeDepth = 4;
    localparam int resetCycles = 8;
    localparam int margin = 20;

    logic               Clock;
    logic               rstN;
    logic               instValid;
    logic               stall;
    logic [31:0]        instPc;
    logic [31:0]        instWord;
    logic               wbValid;
    logic [regIdxW-1:0] wbRd;
    logic [xlen-1:0]    wbData;

    // Three words per case: flags, PC, instruction
    logic [31:0]        caseMem [0:3*maxCases-1];
    int                 numCases;
    int                 cycleCount = 0;
    int                 cycleLimit = 0;
    int                 slotCount;
    int                 valueErrors;
    int                 flowErrors;

    // Architectural state as seen by the next issue
    logic [xlen-1:0]    modelRegs [0:31];
    // Writes in flight, indexed by slot modulo the depth
    logic               pendWr [0:pipeDepth-1];
    logic [regIdxW-1:0] pendRd [0:pipeDepth-1];
    logic [xlen-1:0]    pendData [0:pipeDepth-1];
    // Expected retirements, oldest first
    logic [regIdxW-1:0] expRd [$];
    logic [xlen-1:0]    expData [$];
    int                 expSlot [$];

    clockGen uClock (
        .Clock (Clock),
        .rstN  (rstN)
    );

    coreBackend #(
        .numRegs (32)
    ) uut (
        .Clock     (Clock),
        .rstN      (rstN),
        .instValid (instValid),
        .stall     (stall),
        .instPc    (instPc),
        .instWord  (instWord),
        .wbValid   (wbValid),
        .wbRd      (wbRd),
        .wbData    (wbData)
    );

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    // Returns 0 for anything outside the supported subset
    function automatic logic modelExec(input logic [31:0] inst, input logic [31:0] pc,
                                       input logic [xlen-1:0] rs1Val,
                                       input logic [xlen-1:0] rs2Val,
                                       output logic [xlen-1:0] res);
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [xlen-1:0] immI;
        f3 = inst[14:12];
        f7 = inst[31:25];
        immI = {{20{inst[31]}}, inst[31:20]};
        res = '0;
        case (inst[6:0])
            opcOp: begin
                if (f7 == 7'h20 && f3 == 3'b000) begin
                    res = rs1Val - rs2Val;
                    return 1'b1;
                end
                if (f7 != 7'h00) begin
                    return 1'b0;
                end
                case (f3)
                    3'b000: res = rs1Val + rs2Val;
                    3'b111: res = rs1Val & rs2Val;
                    3'b110: res = rs1Val | rs2Val;
                    3'b100: res = rs1Val ^ rs2Val;
                    3'b010: res = ($signed(rs1Val) < $signed(rs2Val)) ? 32'd1 : 32'd0;
                    3'b001: res = rs1Val << rs2Val[4:0];
                    3'b101: res = rs1Val >> rs2Val[4:0];
                    default: return 1'b0;
                endcase
                return 1'b1;
            end
            opcOpImm: begin
                case (f3)
                    3'b000: res = rs1Val + immI;
                    3'b111: res = rs1Val & immI;
                    3'b110: res = rs1Val | immI;
                    3'b100: res = rs1Val ^ immI;
                    default: return 1'b0;
                endcase
                return 1'b1;
            end
            opcLui: res = {inst[31:12], 12'h000};
            opcAuipc: res = pc + {inst[31:12], 12'h000};
            default: return 1'b0;
        endcase
        return 1'b1;
    endfunction

    // One slot: retire the write from four slots back, then evaluate
    task automatic issueSlot(input logic v, input logic [31:0] pc, input logic [31:0] inst);
        int              idx;
        logic            legal;
        logic [xlen-1:0] res;
        idx = slotCount % pipeDepth;
        if (pendWr[idx] && pendRd[idx] != '0) begin
            modelRegs[pendRd[idx]] = pendData[idx];
        end
        legal = modelExec(inst, pc, modelRegs[inst[19:15]], modelRegs[inst[24:20]], res);
        pendWr[idx] = v && legal;
        pendRd[idx] = inst[11:7];
        pendData[idx] = res;
        if (v && legal && inst[11:7] != 5'd0) begin
            expRd.push_back(inst[11:7]);
            expData.push_back(res);
            expSlot.push_back(slotCount + pipeDepth);
        end
    endtask

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic checkRd(input logic [regIdxW-1:0] got, input logic [regIdxW-1:0] exp);
        if (got !== exp) begin
            $display("FAIL wbRd got 0x%h expected 0x%h at slot %0d", got, exp, slotCount);
            valueErrors++;
        end
    endtask

    task automatic checkData(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
        if (got !== exp) begin
            $display("FAIL wbData got 0x%h expected 0x%h at slot %0d", got, exp, slotCount);
            valueErrors++;
        end
    endtask

    task automatic checkValid(input logic got, input logic exp);
        if (exp && got !== 1'b1) begin
            $display("Missing retirement of x%0d at slot %0d", expRd[0], slotCount);
            flowErrors++;
        end else if (!exp && got !== 1'b0) begin
            $display("Unexpected retirement of x%0d at slot %0d", wbRd, slotCount);
            flowErrors++;
        end
    endtask

    // Retirement due in this slot, in issue order
    task automatic checkRetire;
        logic due;
        due = (expSlot.size() > 0) && (expSlot[0] == slotCount);
        checkValid(wbValid, due);
        if (due) begin
            if (wbValid === 1'b1) begin
                checkRd(wbRd, expRd[0]);
                checkData(wbData, expData[0]);
            end
            void'(expRd.pop_front());
            void'(expData.pop_front());
            void'(expSlot.pop_front());
        end
    endtask

    task automatic driveLine(input logic [31:0] flags, input logic [31:0] pc,
                             input logic [31:0] word);
        instValid = flags[4];
        stall = flags[0];
        instPc = pc;
        instWord = word;
    endtask

    // ------------------------------------------------------------
    // Timeout
    // ------------------------------------------------------------
    always @(posedge Clock) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles, run did not complete", cycleCount);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int i;
        driveLine(32'h0, 32'h0, 32'h0);
        slotCount = 0;
        valueErrors = 0;
        flowErrors = 0;
        for (i = 0; i < 3 * maxCases; i++) begin
            caseMem[i] = 'x;
        end
        for (i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (i = 0; i < pipeDepth; i++) begin
            pendWr[i] = 1'b0;
        end
        $readmemh("tb/backendCases.hex", caseMem);
        numCases = 0;
        while (numCases < maxCases && !$isunknown(caseMem[3*numCases])) begin
            numCases++;
        end
        cycleLimit = numCases + pipeDepth + resetCycles + margin;
        if (numCases == 0) begin
            $display("No cases read from tb/backendCases.hex");
            flowErrors++;
        end

        @(posedge rstN);
        // File lines, then bubbles to drain the pipe
        for (i = 0; i < numCases + pipeDepth; i++) begin
            @(negedge Clock);
            if (i < numCases) begin
                driveLine(caseMem[3*i], caseMem[3*i+1], caseMem[3*i+2]);
            end else begin
                driveLine(32'h0, 32'h0, 32'h0);
            end
            #1;
            if (!stall) begin
                checkRetire();
                issueSlot(instValid, instPc, instWord);
                slotCount++;
            end else begin
                checkValid(wbValid, 1'b0);
            end
        end

        if (expRd.size() != 0) begin
            $display("%0d expected retirements never appeared", expRd.size());
            flowErrors += expRd.size();
        end
        $display("Checks done: %0d value errors, %0d flow errors", valueErrors, flowErrors);
        if (valueErrors + flowErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb/coreBackend_assert.sv */
// Concurrent assertions on reset, writeback index and stall hold for binding into coreBackend
module coreBackend_assert (
    input logic                           Clock,
    input logic                           rstN,
    input logic                           stall,
    input logic                           wbValid,
    input logic [coreIsaPkg::regIdxW-1:0] wbRd,
    input logic [coreIsaPkg::xlen-1:0]    wbData
);

    // Q105H valid cleared by any reset edge
    assert property (@(posedge Clock) !rstN |=> !wbValid)
        else $error("wbValid high after a reset edge");

    // x0 is never reported
    assert property (@(posedge Clock) disable iff (!rstN) wbValid |-> wbRd != '0)
        else $error("wbValid high with wbRd zero");

    // Q105H destination and data hold across a stalled edge
    assert property (@(posedge Clock) disable iff (!rstN)
        stall |=> $stable(wbRd) && $stable(wbData))
        else $error("Q105H state changed during stall");

endmodule

bind coreBackend coreBackend_assert uAssert (
    .Clock   (Clock),
    .rstN    (rstN),
    .stall   (stall),
    .wbValid (wbValid),
    .wbRd    (wbRd),
    .wbData  (wbData)
);
